//--- design/core_config.svh
// core configuration: widths, reset pc, kept opcodes and trap encoding
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// datapath and instruction widths
`define CORE_XLEN 64
`define CORE_ILEN 32

// architectural register count
`define CORE_NREGS 32

// first fetch address after reset
`define CORE_PC_START 64'h8000_0000

// kept major opcodes
`define CORE_OPC_OP     7'h33
`define CORE_OPC_OP_IMM 7'h13
`define CORE_OPC_LUI    7'h37

// halt instruction and the register that carries its code
`define CORE_TRAP_OPCODE 7'h6b
`define CORE_TRAP_REG    10

`endif

//--- design/core_pkg.sv
// core package: shared vector types, enums and the structs passed between stages
`include "core_config.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0] xlen_t;
  typedef logic [`CORE_ILEN-1:0] inst_t;
  typedef logic [$clog2(`CORE_NREGS)-1:0] reg_addr_t;
  typedef logic [7:0] trap_code_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic {
    run_st,
    halt_st
  } run_state_e;

  // instruction paired with the pc it was fetched from
  typedef struct packed {
    logic  valid;
    xlen_t pc;
    inst_t inst;
  } fetch_pkt_t;

  // decoded item with resolved operands
  typedef struct packed {
    logic      valid;
    xlen_t     pc;
    inst_t     inst;
    alu_op_e   op;
    xlen_t     opa;
    xlen_t     opb;
    reg_addr_t rd;
    logic      wen;
  } exec_pkt_t;

  typedef struct packed {
    logic      valid;
    xlen_t     pc;
    inst_t     inst;
    logic      wen;
    reg_addr_t wdest;
    xlen_t     wdata;
  } commit_t;

endpackage

//--- design/fetch_unit.sv
// fetch unit holding the pc register, the instruction request and pc/instruction pairing
`timescale 1ns/10ps
`include "core_config.svh"

module fetch_unit (
  input  logic                clock,
  input  logic                reset,
  input  logic                run_i,
  output logic                imem_req_o,
  output core_pkg::xlen_t     imem_addr_o,
  input  core_pkg::inst_t     imem_inst_i,
  output core_pkg::fetch_pkt_t fetch_o
);

  core_pkg::xlen_t pc_q;
  core_pkg::xlen_t req_pc_q;
  logic            req_q;

  // no request while reset is held
  assign imem_req_o  = run_i && !reset;
  assign imem_addr_o = pc_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q  <= `CORE_PC_START;
      req_q <= 1'b0;
    end else begin
      if (run_i) begin
        pc_q <= pc_q + core_pkg::xlen_t'(4);
      end
      req_q <= imem_req_o;
    end
  end

  // instruction comes back one cycle after the request
  always_ff @(posedge clock) begin
    req_pc_q <= pc_q;
  end

  assign fetch_o.valid = req_q;
  assign fetch_o.pc    = req_pc_q;
  assign fetch_o.inst  = imem_inst_i;

endmodule

//--- design/decode_stage.sv
// decode stage splitting fields, building immediates, selecting the alu op and forwarding operands
`timescale 1ns/10ps
`include "core_config.svh"

module decode_stage (
  input  logic                  clock,
  input  logic                  reset,
  input  core_pkg::fetch_pkt_t  fetch_i,
  output core_pkg::reg_addr_t   rs1_addr_o,
  output core_pkg::reg_addr_t   rs2_addr_o,
  input  core_pkg::xlen_t       rs1_data_i,
  input  core_pkg::xlen_t       rs2_data_i,
  input  core_pkg::xlen_t       ex_fwd_data_i,
  input  core_pkg::exec_pkt_t   ex_item_i,
  input  core_pkg::commit_t     commit_i,
  output core_pkg::exec_pkt_t   exec_o
);

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  core_pkg::reg_addr_t rd;
  core_pkg::xlen_t     imm_i;
  core_pkg::xlen_t     imm_u;
  core_pkg::xlen_t     rs1_val;
  core_pkg::xlen_t     rs2_val;
  logic                op_known;
  core_pkg::exec_pkt_t exec_d;
  core_pkg::exec_pkt_t exec_q;

  // execute result first, then the commit stage, then the register file
  function automatic core_pkg::xlen_t fwd_operand(input core_pkg::reg_addr_t addr,
                                                  input core_pkg::xlen_t rf_data);
    core_pkg::xlen_t value;
    value = rf_data;
    if (addr != '0) begin
      if (ex_item_i.valid && ex_item_i.wen && ex_item_i.rd == addr) begin
        value = ex_fwd_data_i;
      end else if (commit_i.valid && commit_i.wen && commit_i.wdest == addr) begin
        value = commit_i.wdata;
      end
    end
    return value;
  endfunction

  // funct3 map shared by OP and OP-IMM
  // alt is inst[30]
  function automatic core_pkg::alu_op_e funct_to_op(input logic [2:0] f3, input logic alt,
                                                    input logic is_reg);
    core_pkg::alu_op_e op;
    unique case (f3)
      3'b000:  op = (is_reg && alt) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
      3'b001:  op = core_pkg::ALU_SLL;
      3'b010:  op = core_pkg::ALU_SLT;
      3'b011:  op = core_pkg::ALU_SLTU;
      3'b100:  op = core_pkg::ALU_XOR;
      3'b101:  op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
      3'b110:  op = core_pkg::ALU_OR;
      default: op = core_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode     = fetch_i.inst[6:0];
  assign rd         = fetch_i.inst[11:7];
  assign funct3     = fetch_i.inst[14:12];
  assign rs1_addr_o = fetch_i.inst[19:15];
  assign rs2_addr_o = fetch_i.inst[24:20];

  assign imm_i = {{(`CORE_XLEN-12){fetch_i.inst[31]}}, fetch_i.inst[31:20]};
  assign imm_u = {{(`CORE_XLEN-32){fetch_i.inst[31]}}, fetch_i.inst[31:12], 12'b0};

  always_comb begin
    rs1_val = fwd_operand(rs1_addr_o, rs1_data_i);
    rs2_val = fwd_operand(rs2_addr_o, rs2_data_i);
  end

  always_comb begin
    exec_d.valid = fetch_i.valid;
    exec_d.pc    = fetch_i.pc;
    exec_d.inst  = fetch_i.inst;
    exec_d.rd    = rd;
    exec_d.opa   = rs1_val;
    exec_d.opb   = imm_i;
    exec_d.op    = core_pkg::ALU_ADD;
    op_known     = 1'b1;
    case (opcode)
      `CORE_OPC_OP_IMM: begin
        exec_d.op = funct_to_op(funct3, fetch_i.inst[30], 1'b0);
      end
      `CORE_OPC_OP: begin
        exec_d.op  = funct_to_op(funct3, fetch_i.inst[30], 1'b1);
        exec_d.opb = rs2_val;
      end
      `CORE_OPC_LUI: begin
        exec_d.op  = core_pkg::ALU_PASS_B;
        exec_d.opb = imm_u;
      end
      default: begin
        op_known = 1'b0;
      end
    endcase
    // x0 destination never writes
    exec_d.wen = op_known && (rd != '0);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      exec_q.valid <= 1'b0;
    end else begin
      exec_q <= exec_d;
    end
  end

  assign exec_o = exec_q;

endmodule

//--- design/regfile.sv
// register file: 32 x 64 bits, two read ports, commit write port, x0 tied to zero
`timescale 1ns/10ps
`include "core_config.svh"

module regfile (
  input  logic                 clock,
  input  logic                 reset,
  input  core_pkg::reg_addr_t  rs1_addr_i,
  input  core_pkg::reg_addr_t  rs2_addr_i,
  output core_pkg::xlen_t      rs1_data_o,
  output core_pkg::xlen_t      rs2_data_o,
  input  core_pkg::commit_t    commit_i,
  output core_pkg::trap_code_t x10_byte_o
);

  core_pkg::xlen_t regs [`CORE_NREGS];

  // entry 0 is never written so it reads as zero
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `CORE_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (commit_i.valid && commit_i.wen && commit_i.wdest != '0) begin
      regs[commit_i.wdest] <= commit_i.wdata;
    end
  end

  assign rs1_data_o = regs[rs1_addr_i];
  assign rs2_data_o = regs[rs2_addr_i];

  // trap code source
  assign x10_byte_o = regs[`CORE_TRAP_REG][7:0];

endmodule

//--- design/execute_stage.sv
// execute stage: 64-bit alu and the commit register
`timescale 1ns/10ps
`include "core_config.svh"

module execute_stage (
  input  logic                clock,
  input  logic                reset,
  input  logic                run_i,
  input  core_pkg::exec_pkt_t exec_i,
  output core_pkg::xlen_t     fwd_data_o,
  output core_pkg::commit_t   commit_o
);

  core_pkg::xlen_t   alu_res;
  logic [5:0]        shamt;
  logic              trap_seen;
  core_pkg::commit_t commit_d;
  core_pkg::commit_t commit_q;

  assign shamt = exec_i.opb[5:0];

  always_comb begin
    unique case (exec_i.op)
      core_pkg::ALU_ADD:  alu_res = exec_i.opa + exec_i.opb;
      core_pkg::ALU_SUB:  alu_res = exec_i.opa - exec_i.opb;
      core_pkg::ALU_SLL:  alu_res = exec_i.opa << shamt;
      core_pkg::ALU_SLT:  alu_res = {{(`CORE_XLEN-1){1'b0}},
                                     $signed(exec_i.opa) < $signed(exec_i.opb)};
      core_pkg::ALU_SLTU: alu_res = {{(`CORE_XLEN-1){1'b0}}, exec_i.opa < exec_i.opb};
      core_pkg::ALU_XOR:  alu_res = exec_i.opa ^ exec_i.opb;
      core_pkg::ALU_SRL:  alu_res = exec_i.opa >> shamt;
      core_pkg::ALU_SRA:  alu_res = $signed(exec_i.opa) >>> shamt;
      core_pkg::ALU_OR:   alu_res = exec_i.opa | exec_i.opb;
      core_pkg::ALU_AND:  alu_res = exec_i.opa & exec_i.opb;
      default:            alu_res = exec_i.opb;
    endcase
  end

  assign fwd_data_o = alu_res;

  // the item behind a committing trap is squashed in the same cycle
  assign trap_seen = commit_q.valid && (commit_q.inst[6:0] == `CORE_TRAP_OPCODE);

  assign commit_d.valid = exec_i.valid && run_i && !trap_seen;
  assign commit_d.pc    = exec_i.pc;
  assign commit_d.inst  = exec_i.inst;
  assign commit_d.wen   = exec_i.wen;
  assign commit_d.wdest = exec_i.rd;
  assign commit_d.wdata = alu_res;

  always_ff @(posedge clock) begin
    if (reset) begin
      commit_q.valid <= 1'b0;
    end else begin
      commit_q <= commit_d;
    end
  end

  assign commit_o = commit_q;

endmodule

//--- design/run_ctrl.sv
// run/halt controller: stops the core on a committed trap and keeps its code
`timescale 1ns/10ps
`include "core_config.svh"

module run_ctrl (
  input  logic                 clock,
  input  logic                 reset,
  input  core_pkg::commit_t    commit_i,
  input  core_pkg::trap_code_t trap_code_src_i,
  output logic                 run_o,
  output logic                 trap_o,
  output core_pkg::trap_code_t trap_code_o
);

  core_pkg::run_state_e state_q;
  core_pkg::run_state_e state_d;
  core_pkg::trap_code_t trap_code_q;
  logic                 trap_hit;

  assign trap_hit = commit_i.valid && (commit_i.inst[6:0] == `CORE_TRAP_OPCODE);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      core_pkg::run_st:  if (trap_hit) state_d = core_pkg::halt_st;
      default:           state_d = core_pkg::halt_st;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q     <= core_pkg::run_st;
      trap_code_q <= '0;
    end else begin
      state_q <= state_d;
      // x10 still holds its value at the trap commit
      if (state_q == core_pkg::run_st && trap_hit) begin
        trap_code_q <= trap_code_src_i;
      end
    end
  end

  assign run_o       = (state_q == core_pkg::run_st);
  assign trap_o      = (state_q == core_pkg::halt_st);
  assign trap_code_o = trap_code_q;

endmodule

//--- design/perf_counters.sv
// performance counters: run cycles and committed instructions
`timescale 1ns/10ps
`include "core_config.svh"

module perf_counters (
  input  logic              clock,
  input  logic              reset,
  input  logic              run_i,
  input  core_pkg::commit_t commit_i,
  output core_pkg::xlen_t   cycle_cnt_o,
  output core_pkg::xlen_t   instr_cnt_o
);

  core_pkg::xlen_t cycle_q;
  core_pkg::xlen_t instr_q;

  // both freeze once the core halts
  always_ff @(posedge clock) begin
    if (reset) begin
      cycle_q <= '0;
      instr_q <= '0;
    end else if (run_i) begin
      cycle_q <= cycle_q + core_pkg::xlen_t'(1);
      if (commit_i.valid) begin
        instr_q <= instr_q + core_pkg::xlen_t'(1);
      end
    end
  end

  assign cycle_cnt_o = cycle_q;
  assign instr_cnt_o = instr_q;

endmodule

//--- design/core_top.sv
// core top level: four-stage rv64 integer pipeline with commit and trap outputs
`timescale 1ns/10ps
`include "core_config.svh"

module core_top (
  input  logic                 clock,
  input  logic                 reset,
  output logic                 imem_req_o,
  output core_pkg::xlen_t      imem_addr_o,
  input  core_pkg::inst_t      imem_inst_i,
  output core_pkg::commit_t    commit_o,
  output logic                 trap_o,
  output core_pkg::trap_code_t trap_code_o,
  output core_pkg::xlen_t      cycle_cnt_o,
  output core_pkg::xlen_t      instr_cnt_o
);

  logic                 run;
  core_pkg::fetch_pkt_t fetch_pkt;
  core_pkg::exec_pkt_t  exec_pkt;
  core_pkg::reg_addr_t  rs1_addr;
  core_pkg::reg_addr_t  rs2_addr;
  core_pkg::xlen_t      rs1_data;
  core_pkg::xlen_t      rs2_data;
  core_pkg::xlen_t      ex_fwd_data;
  core_pkg::trap_code_t x10_byte;

  fetch_unit fetch_unit_inst (
    .clock       (clock),
    .reset       (reset),
    .run_i       (run),
    .imem_req_o  (imem_req_o),
    .imem_addr_o (imem_addr_o),
    .imem_inst_i (imem_inst_i),
    .fetch_o     (fetch_pkt)
  );

  decode_stage decode_stage_inst (
    .clock         (clock),
    .reset         (reset),
    .fetch_i       (fetch_pkt),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .ex_fwd_data_i (ex_fwd_data),
    .ex_item_i     (exec_pkt),
    .commit_i      (commit_o),
    .exec_o        (exec_pkt)
  );

  regfile regfile_inst (
    .clock      (clock),
    .reset      (reset),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .commit_i   (commit_o),
    .x10_byte_o (x10_byte)
  );

  execute_stage execute_stage_inst (
    .clock      (clock),
    .reset      (reset),
    .run_i      (run),
    .exec_i     (exec_pkt),
    .fwd_data_o (ex_fwd_data),
    .commit_o   (commit_o)
  );

  run_ctrl run_ctrl_inst (
    .clock           (clock),
    .reset           (reset),
    .commit_i        (commit_o),
    .trap_code_src_i (x10_byte),
    .run_o           (run),
    .trap_o          (trap_o),
    .trap_code_o     (trap_code_o)
  );

  perf_counters perf_counters_inst (
    .clock       (clock),
    .reset       (reset),
    .run_i       (run),
    .commit_i    (commit_o),
    .cycle_cnt_o (cycle_cnt_o),
    .instr_cnt_o (instr_cnt_o)
  );

endmodule

//--- bench/core_props.sv
// core properties: halt behavior and commit sanity on the top level
`timescale 1ns/10ps

module core_props (
  input logic              clock,
  input logic              reset,
  input logic              imem_req_i,
  input core_pkg::commit_t commit_i,
  input logic              trap_i
);

  // nothing commits once halted
  no_commit_halted: assert property (@(posedge clock) disable iff (reset)
    trap_i |-> !commit_i.valid)
    else $error("commit valid while the core is halted");

  trap_sticky: assert property (@(posedge clock) disable iff (reset)
    trap_i |=> trap_i)
    else $error("trap fell outside reset");

  no_fetch_halted: assert property (@(posedge clock) disable iff (reset)
    trap_i |-> !imem_req_i)
    else $error("instruction request while the core is halted");

  // x0 is never a write target
  no_x0_write: assert property (@(posedge clock) disable iff (reset)
    (commit_i.valid && commit_i.wen) |-> (commit_i.wdest != '0))
    else $error("commit writes x0");

endmodule

//--- bench/core_tb.sv
// core testbench driving a random alu program that ends in a trap against an in-order model
`timescale 1ns/10ps
`include "core_config.svh"

module core_tb;

  localparam int N       = 40;
  localparam int TIMEOUT = 500;

  logic                 clock;
  logic                 reset;
  logic                 imem_req;
  core_pkg::xlen_t      imem_addr;
  core_pkg::inst_t      imem_inst;
  core_pkg::commit_t    commit;
  logic                 trap;
  core_pkg::trap_code_t trap_code;
  core_pkg::xlen_t      cycle_cnt;
  core_pkg::xlen_t      instr_cnt;

  core_pkg::inst_t rom [N+1];
  core_pkg::xlen_t exp_wdata [N+1];
  logic            exp_wen [N+1];
  core_pkg::xlen_t model_regs [32];
  int              errors;
  int              checks;
  int              commit_idx;
  int              cycles;

  core_top core_top_inst (
    .clock       (clock),
    .reset       (reset),
    .imem_req_o  (imem_req),
    .imem_addr_o (imem_addr),
    .imem_inst_i (imem_inst),
    .commit_o    (commit),
    .trap_o      (trap),
    .trap_code_o (trap_code),
    .cycle_cnt_o (cycle_cnt),
    .instr_cnt_o (instr_cnt)
  );

  bind core_top core_props core_props_inst (
    .clock      (clock),
    .reset      (reset),
    .imem_req_i (imem_req_o),
    .commit_i   (commit_o),
    .trap_i     (trap_o)
  );

  always #10 clock = ~clock;

  // past the trap the rom returns zero
  function automatic core_pkg::inst_t rom_read(input core_pkg::xlen_t addr);
    core_pkg::xlen_t offs;
    offs = (addr - `CORE_PC_START) >> 2;
    return (offs <= core_pkg::xlen_t'(N)) ? rom[offs[5:0]] : '0;
  endfunction

  always @(posedge clock) begin
    if (imem_req) begin
      imem_inst <= rom_read(imem_addr);
    end
  end

  // rv64 semantics of the kept instructions
  function automatic core_pkg::xlen_t ref_result(input core_pkg::inst_t inst,
                                                 input core_pkg::xlen_t a,
                                                 input core_pkg::xlen_t b_reg);
    core_pkg::xlen_t b;
    logic [5:0]      sh;
    logic            is_op;
    is_op = (inst[6:0] == `CORE_OPC_OP);
    b     = is_op ? b_reg : {{52{inst[31]}}, inst[31:20]};
    sh    = b[5:0];
    if (inst[6:0] == `CORE_OPC_LUI) begin
      return {{32{inst[31]}}, inst[31:12], 12'h000};
    end
    case (inst[14:12])
      3'b000:  return (is_op && inst[30]) ? a - b : a + b;
      3'b001:  return a << sh;
      3'b010:  return {63'b0, $signed(a) < $signed(b)};
      3'b011:  return {63'b0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return inst[30] ? core_pkg::xlen_t'($signed(a) >>> sh) : a >> sh;
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic build_program();
    int unsigned kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  prev_rd;
    logic [4:0]  prev2_rd;
    logic [2:0]  f3;
    logic        alt;
    prev_rd  = 5'd1;
    prev2_rd = 5'd2;
    for (int i = 0; i < N; i++) begin
      kind = $urandom % 3;
      rd   = ($urandom % 8 == 0) ? 5'd0 : 5'(1 + $urandom % 12);
      // half the sources read the previous result
      rs1  = ($urandom % 2 == 0) ? prev_rd : 5'($urandom % 13);
      // rs2 often reads the result two back from the commit stage
      rs2  = ($urandom % 2 == 0) ? prev2_rd : 5'($urandom % 13);
      f3   = 3'($urandom);
      if (i == N - 1) begin
        kind = 1;
        f3   = 3'b000;
        rd   = 5'd10;
      end
      alt = ($urandom % 2 == 1) && (f3 == 3'b101 || (kind == 2 && f3 == 3'b000));
      if (kind == 0) begin
        rom[i] = {20'($urandom), rd, `CORE_OPC_LUI};
      end else if (kind == 1 && (f3 == 3'b001 || f3 == 3'b101)) begin
        rom[i] = {1'b0, alt, 4'b0, 6'($urandom), rs1, f3, rd, `CORE_OPC_OP_IMM};
      end else if (kind == 1) begin
        rom[i] = {12'($urandom), rs1, f3, rd, `CORE_OPC_OP_IMM};
      end else begin
        rom[i] = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, `CORE_OPC_OP};
      end
      prev2_rd = prev_rd;
      prev_rd  = rd;
    end
    rom[N] = {25'b0, `CORE_TRAP_OPCODE};
  endtask

  function automatic void run_reference();
    core_pkg::xlen_t res;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    for (int i = 0; i < N; i++) begin
      res          = ref_result(rom[i], model_regs[rom[i][19:15]], model_regs[rom[i][24:20]]);
      exp_wen[i]   = (rom[i][11:7] != 5'd0);
      exp_wdata[i] = res;
      if (exp_wen[i]) begin
        model_regs[rom[i][11:7]] = res;
      end
    end
    exp_wen[N]   = 1'b0;
    exp_wdata[N] = '0;
  endfunction

  task automatic check_value(input string name, input core_pkg::xlen_t expected,
                             input core_pkg::xlen_t actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // commits are compared in program order
  always @(negedge clock) begin
    if (!reset && commit.valid) begin
      if (commit_idx > N) begin
        errors++;
        $display("ERROR: unexpected commit at pc %h after the trap", commit.pc);
      end else begin
        check_value($sformatf("commit %0d pc", commit_idx),
                    `CORE_PC_START + core_pkg::xlen_t'(4 * commit_idx), commit.pc);
        check_value($sformatf("commit %0d inst", commit_idx),
                    core_pkg::xlen_t'(rom[commit_idx]), core_pkg::xlen_t'(commit.inst));
        check_value($sformatf("commit %0d wen", commit_idx),
                    core_pkg::xlen_t'(exp_wen[commit_idx]), core_pkg::xlen_t'(commit.wen));
        check_value($sformatf("commit %0d wdest", commit_idx),
                    core_pkg::xlen_t'(rom[commit_idx][11:7]), core_pkg::xlen_t'(commit.wdest));
        if (exp_wen[commit_idx]) begin
          check_value($sformatf("commit %0d wdata", commit_idx),
                      exp_wdata[commit_idx], commit.wdata);
        end
      end
      commit_idx++;
    end
  end

  initial begin
    void'($urandom(32'hb6f9_31d8));
    clock      = 1'b0;
    reset      = 1'b1;
    imem_inst  = '0;
    errors     = 0;
    checks     = 0;
    commit_idx = 0;
    build_program();
    run_reference();
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    cycles = 0;
    while (!trap && cycles < TIMEOUT) begin
      @(negedge clock);
      cycles++;
    end
    if (!trap) begin
      errors++;
      $display("ERROR: core never halted within %0d cycles", TIMEOUT);
    end else begin
      // a few more cycles so a stray commit would show up
      for (int i = 0; i < 4; i++) begin
        @(negedge clock);
      end
      check_value("trap code", core_pkg::xlen_t'(model_regs[10][7:0]),
                  core_pkg::xlen_t'(trap_code));
      check_value("commit count", core_pkg::xlen_t'(N + 1), core_pkg::xlen_t'(commit_idx));
      check_value("instr count", core_pkg::xlen_t'(N + 1), instr_cnt);
      check_value("cycle count", core_pkg::xlen_t'(N + 4), cycle_cnt);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+design
design/core_pkg.sv
design/fetch_unit.sv
design/decode_stage.sv
design/regfile.sv
design/execute_stage.sv
design/run_ctrl.sv
design/perf_counters.sv
design/core_top.sv
bench/core_props.sv
bench/core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the core testbench with verilator, pass decided from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module core_tb \
  --Mdir obj_dir -o core_tb_sim \
  && ./obj_dir/core_tb_sim > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -qx "Verification passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
